// ==== sources.f ====
smc_state_pkg.sv
smc_timing_pkg.sv
smc_access_latch.sv
smc_write_strobe.sv
smc_full_cycle.sv
smc_read_strobe.sv
smc_strobe_top.sv
smc_strobe_sva.sv
tb_smc_strobe.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the strobe stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
log=sim.log
verilator --binary --timing --assert --top-module tb_smc_strobe -f sources.f -o tb_smc_strobe
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi
./obj_dir/tb_smc_strobe +verilator+error+limit+10000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi
if grep -q "Test FAILED" "$log"; then
   echo "Simulation reported a failure"
   exit 1
fi
echo "Simulation passed"
exit 0

// ==== tb_smc_strobe.sv ====
// Testbench: clock, reset, random stimulus, reference model, compare tasks, verdict
`timescale 1ns/1ps

module tb_smc_strobe
   import smc_state_pkg::*, smc_timing_pkg::*;
#(
   parameter int num_bytes = DEF_NUM_BYTES  // Lane count under test
);

   localparam int num_cycles     = 2000;              // Random cycles after reset
   localparam int timeout_cycles = num_cycles + 100;  // Reset and drain margin

   logic                 sys_clk18;
   logic                 n_sys_reset18;
   logic                 n_read;
   logic                 cs;
   logic [num_bytes-1:0] n_be;
   logic                 valid_access;
   logic                 smc_done;
   logic                 mac_done;
   smc_state_e           r_smc_currentstate;
   smc_state_e           smc_nextstate;
   edge_phase_t          r_wele_count;
   ws_count_t            r_ws_count;
   edge_phase_t          r_wele_store;
   edge_phase_t          r_wete_store;
   edge_phase_t          r_oete_store;
   ws_count_t            r_ws_store;
   logic                 n_r_read;
   logic                 r_cs;
   logic                 smc_busy;
   logic [num_bytes-1:0] n_r_we;
   logic                 n_r_wr;
   logic                 smc_n_ext_oe;
   logic                 r_full;
   logic                 smc_n_rd;

   // Model state, one cycle ahead of the DUT outputs
   logic                 exp_read;
   logic                 exp_cs;
   logic                 exp_busy;
   logic [num_bytes-1:0] exp_we;
   logic                 exp_wr;
   logic                 exp_oe;
   logic                 exp_full;
   logic                 exp_rd;

   int    seed = 61;
   int    error_count = 0;
   int    assert_fails = 0;
   int    cycle_count = 0;
   int    branch_hits [5] = '{0, 0, 0, 0, 0};  // r_full branches into RW
   string branch_names [5] = '{"LE", "STORE", "RW/FLOAT valid", "RW/FLOAT done",
                               "RW/FLOAT other"};

   smc_strobe_top #(.num_bytes(num_bytes)) smc_strobe_top_inst (.*);

   initial sys_clk18 = 1'b0;
   always #5 sys_clk18 = ~sys_clk18;  // 10 ns period

   //--------------------------------------------------
   // Reference model
   //--------------------------------------------------
   // Edge setting below the low two bits, or whole cycles left
   function automatic logic edge_before(edge_phase_t edge_set, ws_count_t ws);
      int value;
      value = int'(ws);
      return (int'(edge_set) < value % 4) || (value / 4 != 0);
   endfunction

   function automatic logic write_ref(logic valid, logic rd_dir, logic held_dir,
                                      smc_state_e nxt);
      if (nxt == STORE)
         return 1'b0;
      return (valid && rd_dir) || (!valid && held_dir);
   endfunction

   // Held access drives the bus only when not going idle
   function automatic logic drive_ref(logic valid, logic rd_dir, logic held_dir,
                                      smc_state_e nxt);
      if (nxt == STORE)
         return 1'b0;
      return (valid && rd_dir) || (!valid && held_dir && nxt != IDLE);
   endfunction

   function automatic logic full_ref(logic valid, logic done, smc_state_e cur,
                                     smc_state_e nxt, edge_phase_t wele_cnt,
                                     edge_phase_t wele_st, edge_phase_t wete_st,
                                     ws_count_t ws_cnt, ws_count_t ws_st);
      int cnt;
      cnt = int'(ws_cnt);
      if (nxt != RW)
         return 1'b0;
      if (cur == LE)
         return edge_before(wete_st, ws_cnt) && (wele_cnt < 2'd2);
      if (cur == STORE)
         return edge_before(wete_st, ws_cnt) && (wele_cnt == 2'd0);
      if (cur != RW && cur != FLOAT)
         return 1'b0;
      if (valid)
         return 1'b0;  // New access restarts the timing
      if (done)
         return edge_before(wete_st, ws_st) && (wele_st == 2'd0);
      if (wele_cnt >= 2'd2)
         return 1'b0;
      if (wete_st == 2'd3)
         return cnt > 4;
      return (int'(wete_st) + 1 < cnt % 4) || (cnt / 4 != 0);  // No wrap below 3
   endfunction

   function automatic logic read_ref(logic valid, logic rd_dir, logic held_dir,
                                     smc_state_e cur, smc_state_e nxt,
                                     edge_phase_t oete_st, ws_count_t ws_cnt,
                                     ws_count_t ws_st);
      int   cnt;
      int   st;
      logic edge_ok;
      cnt = int'(ws_cnt);
      st  = int'(ws_st);
      if (nxt != RW)
         return 1'b1;
      if (valid)
         return rd_dir;
      if (cur == LE || cur == STORE)
         edge_ok = (int'(oete_st) <= st % 4) || (st / 4 != 0) || (st == 0);
      else
         edge_ok = (int'(oete_st) < cnt % 4) || (cnt / 4 != 0) || (cnt == 0);
      return edge_ok ? held_dir : 1'b1;
   endfunction

   //--------------------------------------------------
   // Compare tasks
   //--------------------------------------------------
   task automatic check_bit(string name, logic actual, logic expected);
      if (actual !== expected)
      begin
         $display("ERR %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
         error_count++;
      end
   endtask

   task automatic check_lanes(string name, logic [num_bytes-1:0] actual,
                              logic [num_bytes-1:0] expected);
      if (actual !== expected)
      begin
         $display("ERR %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
         error_count++;
      end
   endtask

   //--------------------------------------------------
   // Stimulus
   //--------------------------------------------------
   function automatic smc_state_e pick_state(int r);
      case ((r & 32'h7fff) % 5)
         0:       return IDLE;
         1:       return LE;
         2:       return RW;
         3:       return STORE;
         default: return FLOAT;
      endcase
   endfunction

   // Half the draws are short counts, zero included
   function automatic ws_count_t pick_wait(int r);
      if (r[8])
         return ws_count_t'({5'd0, r[2:0]});
      return ws_count_t'(r[7:0]);
   endfunction

   task automatic drive_random();
      int r;
      r = $random(seed);
      valid_access       = (r[1:0] == 2'b00);  // About a quarter
      smc_done           = (r[3:2] == 2'b00);
      mac_done           = r[4];               // About half
      n_read             = r[5];
      cs                 = r[6];
      n_be               = r[7 +: num_bytes];
      r_wele_count       = r[13:12];
      r_wele_store       = r[15:14];
      r_wete_store       = r[17:16];
      r_oete_store       = r[19:18];
      r_smc_currentstate = pick_state($random(seed));
      smc_nextstate      = pick_state($random(seed));
      r_ws_count         = pick_wait($random(seed));
      r_ws_store         = pick_wait($random(seed));
   endtask

   //--------------------------------------------------
   // Compare process
   //--------------------------------------------------
   always @(posedge sys_clk18)
   begin
      if (!n_sys_reset18)
      begin
         exp_read = 1'b0;  // Reset values, checked at the first edge after release
         exp_cs   = 1'b0;
         exp_busy = 1'b0;
         exp_we   = '1;
         exp_wr   = 1'b1;
         exp_oe   = 1'b1;
         exp_full = 1'b0;
         exp_rd   = 1'b1;
      end
      else
      begin
         check_bit("n_r_read", n_r_read, exp_read);
         check_bit("r_cs", r_cs, exp_cs);
         check_bit("smc_busy", smc_busy, exp_busy);
         check_lanes("n_r_we", n_r_we, exp_we);
         check_bit("n_r_wr", n_r_wr, exp_wr);
         check_bit("smc_n_ext_oe", smc_n_ext_oe, exp_oe);
         check_bit("r_full", r_full, exp_full);
         check_bit("smc_n_rd", smc_n_rd, exp_rd);
         if (smc_nextstate == RW)
         begin
            if (r_smc_currentstate == LE)
               branch_hits[0]++;
            else if (r_smc_currentstate == STORE)
               branch_hits[1]++;
            else if (r_smc_currentstate == RW || r_smc_currentstate == FLOAT)
               branch_hits[valid_access ? 2 : (smc_done ? 3 : 4)]++;
         end
         // Strobes use the held direction before the latch moves
         exp_busy = (smc_nextstate != IDLE);
         exp_wr   = !write_ref(valid_access, n_read, exp_read, smc_nextstate);
         exp_we   = exp_wr ? '1 : n_be;
         exp_oe   = !drive_ref(valid_access, n_read, exp_read, smc_nextstate);
         exp_full = full_ref(valid_access, smc_done, r_smc_currentstate, smc_nextstate,
                             r_wele_count, r_wele_store, r_wete_store, r_ws_count, r_ws_store);
         exp_rd   = read_ref(valid_access, n_read, exp_read, r_smc_currentstate,
                             smc_nextstate, r_oete_store, r_ws_count, r_ws_store);
         if (valid_access)
         begin
            exp_read = n_read;
            exp_cs   = cs;
         end
         else if (smc_done && mac_done)
         begin
            exp_read = 1'b0;
            exp_cs   = 1'b0;
         end
      end
   end

   always @(posedge sys_clk18)
   begin
      cycle_count++;
      if (cycle_count >= timeout_cycles)
      begin
         $display("Timeout: run still going after %0d cycles", cycle_count);
         $display("Test FAILED");
         $finish;
      end
   end

   //--------------------------------------------------
   // Main sequence
   //--------------------------------------------------
   initial
   begin
      n_sys_reset18      = 1'b0;
      n_read             = 1'b1;
      cs                 = 1'b0;
      n_be               = '1;
      valid_access       = 1'b0;
      smc_done           = 1'b0;
      mac_done           = 1'b0;
      r_smc_currentstate = IDLE;
      smc_nextstate      = IDLE;
      r_wele_count       = '0;
      r_ws_count         = '0;
      r_wele_store       = '0;
      r_wete_store       = '0;
      r_oete_store       = '0;
      r_ws_store         = '0;
      repeat (3) @(posedge sys_clk18);
      @(negedge sys_clk18);
      n_sys_reset18 = 1'b1;
      repeat (num_cycles)
      begin
         @(negedge sys_clk18);
         drive_random();
      end
      repeat (2) @(posedge sys_clk18);  // Last expected values get compared
      @(negedge sys_clk18);
      for (int i = 0; i < 5; i++)
      begin
         if (branch_hits[i] == 0)
         begin
            $display("r_full branch %s was never exercised", branch_names[i]);
            error_count++;
         end
      end
      assert_fails = smc_strobe_top_inst.smc_strobe_sva_inst.fail_count;
      $display("Errors: %0d check, %0d assertion", error_count, assert_fails);
      if (error_count == 0 && assert_fails == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

// ==== smc_strobe_sva.sv ====
// Bound assertions: reset values, write lanes against write strobe, busy timing
`timescale 1ns/1ps

module smc_strobe_sva
   import smc_state_pkg::*, smc_timing_pkg::*;
#(
   parameter int num_bytes = DEF_NUM_BYTES
)
(
   input logic                 sys_clk18,
   input logic                 n_sys_reset18,
   input smc_state_e           smc_nextstate,
   input logic                 n_r_read,
   input logic                 r_cs,
   input logic                 smc_busy,
   input logic [num_bytes-1:0] n_r_we,
   input logic                 n_r_wr,
   input logic                 smc_n_ext_oe,
   input logic                 r_full,
   input logic                 smc_n_rd
);

   int fail_count = 0;  // Failed assertions so far

   // Falling edge sample, clear of register updates
   reset_values_a: assert property (@(negedge sys_clk18) !n_sys_reset18 |->
      (!n_r_read && !r_cs && !smc_busy && (&n_r_we) && n_r_wr && smc_n_ext_oe &&
       !r_full && smc_n_rd))
   else
   begin
      $error("Outputs leave their reset values while reset is low");
      fail_count++;
   end

   // Lanes idle whenever the write strobe is off
   lanes_idle_a: assert property (@(posedge sys_clk18) disable iff (!n_sys_reset18)
      n_r_wr |-> (n_r_we == '1))
   else
   begin
      $error("Byte write enable active without the write strobe");
      fail_count++;
   end

   busy_a: assert property (@(posedge sys_clk18) disable iff (!n_sys_reset18)
      smc_busy == $past(smc_nextstate != IDLE))
   else
   begin
      $error("Busy flag does not follow the previous next state");
      fail_count++;
   end

endmodule

bind smc_strobe_top smc_strobe_sva #(.num_bytes(num_bytes)) smc_strobe_sva_inst (
   .sys_clk18, .n_sys_reset18, .smc_nextstate, .n_r_read, .r_cs, .smc_busy, .n_r_we,
   .n_r_wr, .smc_n_ext_oe, .r_full, .smc_n_rd);

// ==== smc_strobe_top.sv ====
// Strobe stage top level: access latch, write strobe, full-cycle and read strobe
`timescale 1ns/1ps

module smc_strobe_top
   import smc_state_pkg::*, smc_timing_pkg::*;
#(
   parameter int num_bytes = DEF_NUM_BYTES  // Byte lanes, 2 or 4
)
(
   input  logic                 sys_clk18,          // System clock
   input  logic                 n_sys_reset18,      // Async reset, active low
   input  logic                 n_read,             // Low for read
   input  logic                 cs,                 // Chip select
   input  logic [num_bytes-1:0] n_be,               // Byte enables, active low
   input  logic                 valid_access,       // Load strobe
   input  logic                 smc_done,           // Access finished
   input  logic                 mac_done,           // Transfer finished
   input  smc_state_e           r_smc_currentstate, // FSM current state
   input  smc_state_e           smc_nextstate,      // FSM next state
   input  edge_phase_t          r_wele_count,       // Write leading edge counter
   input  ws_count_t            r_ws_count,         // Wait-state counter
   input  edge_phase_t          r_wele_store,       // Write leading edge setting
   input  edge_phase_t          r_wete_store,       // Write trailing edge setting
   input  edge_phase_t          r_oete_store,       // Read trailing edge setting
   input  ws_count_t            r_ws_store,         // Wait-state setting
   output logic                 n_r_read,           // Held direction
   output logic                 r_cs,               // Held chip select
   output logic                 smc_busy,           // Controller active
   output logic [num_bytes-1:0] n_r_we,             // Byte write enables
   output logic                 n_r_wr,             // Write strobe
   output logic                 smc_n_ext_oe,       // External driver enable
   output logic                 r_full,             // Full-cycle write
   output logic                 smc_n_rd            // Read strobe
);

   smc_access_latch smc_access_latch_inst (
      .sys_clk18, .n_sys_reset18, .valid_access, .smc_done, .mac_done,
      .n_read, .cs, .n_r_read, .r_cs);

   // Lane count only matters to the write enables
   smc_write_strobe #(.num_bytes(num_bytes)) smc_write_strobe_inst (
      .sys_clk18, .n_sys_reset18, .valid_access, .n_read, .n_r_read, .n_be,
      .smc_nextstate, .n_r_we, .n_r_wr, .smc_n_ext_oe, .smc_busy);

   smc_full_cycle smc_full_cycle_inst (
      .sys_clk18, .n_sys_reset18, .valid_access, .smc_done, .r_smc_currentstate,
      .smc_nextstate, .r_wele_count, .r_wele_store, .r_wete_store, .r_ws_count,
      .r_ws_store, .r_full);

   smc_read_strobe smc_read_strobe_inst (
      .sys_clk18, .n_sys_reset18, .valid_access, .n_read, .n_r_read,
      .r_smc_currentstate, .smc_nextstate, .r_oete_store, .r_ws_count,
      .r_ws_store, .smc_n_rd);

endmodule

// ==== smc_read_strobe.sv ====
// Read strobe stage: registered read strobe timed against the output-enable edge
`timescale 1ns/1ps

module smc_read_strobe
   import smc_state_pkg::*, smc_timing_pkg::*;
(
   input  logic        sys_clk18,          // System clock
   input  logic        n_sys_reset18,      // Async reset, active low
   input  logic        valid_access,       // New access this cycle
   input  logic        n_read,             // Direction of the new access
   input  logic        n_r_read,           // Held direction
   input  smc_state_e  r_smc_currentstate, // FSM current state
   input  smc_state_e  smc_nextstate,      // FSM next state
   input  edge_phase_t r_oete_store,       // Output-enable trailing edge
   input  ws_count_t   r_ws_count,         // Wait-state counter
   input  ws_count_t   r_ws_store,         // Wait-state setting
   output logic        smc_n_rd            // Read strobe, active low
);

   logic from_edge;     // Entering RW from LE or STORE
   logic store_rd_ok;   // Read edge reached, judged on the setting
   logic count_rd_ok;   // Read edge reached, judged on the counter
   logic rd_next;

   assign from_edge = (r_smc_currentstate == LE) | (r_smc_currentstate == STORE);

   // Zero wait states always allow the strobe
   assign store_rd_ok = (r_oete_store <= r_ws_store.fine) |
                        (r_ws_store.coarse != 6'd0) |
                        (r_ws_store == 8'd0);
   assign count_rd_ok = (r_oete_store < r_ws_count.fine) |
                        (r_ws_count.coarse != 6'd0) |
                        (r_ws_count == 8'd0);

   //--------------------------------------------------
   // Strobe select
   //--------------------------------------------------
   always_comb
   begin
      rd_next = 1'b1;  // Inactive outside RW
      if (smc_nextstate == RW)
      begin
         if (valid_access)
            rd_next = n_read;  // Write leaves the strobe high
         else if (from_edge)
            rd_next = store_rd_ok ? n_r_read : 1'b1;
         else
            rd_next = count_rd_ok ? n_r_read : 1'b1;
      end
   end

   always_ff @(posedge sys_clk18 or negedge n_sys_reset18)
   begin
      if (!n_sys_reset18)
         smc_n_rd <= 1'b1;
      else
         smc_n_rd <= rd_next;
   end

endmodule

// ==== smc_full_cycle.sv ====
// Full-cycle write flag: decides if the next write strobe lasts a whole clock
`timescale 1ns/1ps

module smc_full_cycle
   import smc_state_pkg::*, smc_timing_pkg::*;
(
   input  logic        sys_clk18,          // System clock
   input  logic        n_sys_reset18,      // Async reset, active low
   input  logic        valid_access,       // New access this cycle
   input  logic        smc_done,           // Access finished
   input  smc_state_e  r_smc_currentstate, // FSM current state
   input  smc_state_e  smc_nextstate,      // FSM next state
   input  edge_phase_t r_wele_count,       // Write leading edge counter
   input  edge_phase_t r_wele_store,       // Write leading edge setting
   input  edge_phase_t r_wete_store,       // Write trailing edge setting
   input  ws_count_t   r_ws_count,         // Wait-state counter
   input  ws_count_t   r_ws_store,         // Wait-state setting
   output logic        r_full              // Full-cycle write strobe
);

   logic        wele_cnt_low;   // Leading edge count below 2
   logic        cnt_long;       // Count outlasts the trailing edge
   logic        store_long;     // Setting outlasts the trailing edge
   edge_phase_t wete_plus1;     // Trailing edge one phase later, wraps
   logic        rw_long;        // Mid-access check while in RW/FLOAT
   logic        full_next;

   assign wele_cnt_low = (r_wele_count < 2'd2);

   // Trailing edge below the sub-phase, or any whole cycles left
   assign cnt_long   = (r_wete_store < r_ws_count.fine) | (r_ws_count.coarse != 6'd0);
   assign store_long = (r_wete_store < r_ws_store.fine) | (r_ws_store.coarse != 6'd0);

   assign wete_plus1 = r_wete_store + 2'd1;

   // Trailing edge at 3 needs more than one whole cycle plus a phase
   always_comb
   begin
      if (r_wete_store == 2'd3)
         rw_long = (r_ws_count > 8'd4);
      else
         rw_long = (wete_plus1 < r_ws_count.fine) | (r_ws_count.coarse != 6'd0);
   end

   //--------------------------------------------------
   // Decision per current state
   //--------------------------------------------------
   always_comb
   begin
      full_next = 1'b0;  // Cleared unless heading into RW
      if (smc_nextstate == RW)
      begin
         case (r_smc_currentstate)
            LE:    full_next = cnt_long & wele_cnt_low;
            STORE: full_next = cnt_long & (r_wele_count == 2'd0);
            RW, FLOAT:
            begin
               if (valid_access)
                  full_next = 1'b0;  // Fresh access restarts timing
               else if (smc_done)
                  full_next = store_long & (r_wele_store == 2'd0);  // Next of a burst
               else
                  full_next = rw_long & wele_cnt_low;
            end
            default: full_next = 1'b0;
         endcase
      end
   end

   always_ff @(posedge sys_clk18 or negedge n_sys_reset18)
   begin
      if (!n_sys_reset18)
         r_full <= 1'b0;
      else
         r_full <= full_next;
   end

endmodule

// ==== smc_write_strobe.sv ====
// Write strobe stage: byte write enables, write strobe, bus drive enable, busy
`timescale 1ns/1ps

module smc_write_strobe
   import smc_state_pkg::*, smc_timing_pkg::*;
#(
   parameter int num_bytes = DEF_NUM_BYTES  // Byte lanes, 2 or 4
)
(
   input  logic                 sys_clk18,     // System clock
   input  logic                 n_sys_reset18, // Async reset, active low
   input  logic                 valid_access,  // New access this cycle
   input  logic                 n_read,        // Direction of the new access
   input  logic                 n_r_read,      // Held direction
   input  logic [num_bytes-1:0] n_be,          // Byte enables, active low
   input  smc_state_e           smc_nextstate, // FSM next state
   output logic [num_bytes-1:0] n_r_we,        // Byte write enables, active low
   output logic                 n_r_wr,        // Write strobe, active low
   output logic                 smc_n_ext_oe,  // External driver enable, active low
   output logic                 smc_busy       // Controller active
);

   logic new_write;   // Write starting now
   logic held_write;  // Write of an access already latched
   logic not_store;   // Strobe stays off while storing
   logic wr_cond;     // Write strobe fires
   logic oe_cond;     // Bus drivers on

   assign not_store  = (smc_nextstate != STORE);
   assign new_write  = valid_access & n_read;
   assign held_write = ~valid_access & n_r_read;

   assign wr_cond = not_store & (new_write | held_write);
   // Held access only drives the bus while not going idle
   assign oe_cond = not_store &
                    (new_write | (held_write & (smc_nextstate != IDLE)));

   //--------------------------------------------------
   // Write strobes and driver enable
   //--------------------------------------------------
   always_ff @(posedge sys_clk18 or negedge n_sys_reset18)
   begin
      if (!n_sys_reset18)
      begin
         n_r_we       <= '1;
         n_r_wr       <= 1'b1;
         smc_n_ext_oe <= 1'b1;
      end
      else
      begin
         n_r_we       <= wr_cond ? n_be : '1;  // Lanes only during a write
         n_r_wr       <= ~wr_cond;
         smc_n_ext_oe <= ~oe_cond;
      end
   end

   // Busy whenever the FSM leaves idle
   always_ff @(posedge sys_clk18 or negedge n_sys_reset18)
   begin
      if (!n_sys_reset18)
         smc_busy <= 1'b0;
      else
         smc_busy <= (smc_nextstate != IDLE);
   end

endmodule

// ==== smc_access_latch.sv ====
// Access latch: read/write direction and chip select held over an access
`timescale 1ns/1ps

module smc_access_latch
(
   input  logic sys_clk18,     // System clock
   input  logic n_sys_reset18, // Async reset, active low
   input  logic valid_access,  // Load strobe for a new access
   input  logic smc_done,      // Current access finished
   input  logic mac_done,      // Last access of a multiple access
   input  logic n_read,        // Direction, low for read
   input  logic cs,            // Chip select of the new access
   output logic n_r_read,      // Held direction
   output logic r_cs           // Held chip select
);

   logic access_end;  // Whole transfer over

   // Both done strobes together end the transfer
   assign access_end = smc_done & mac_done;

   //--------------------------------------------------
   // Direction store
   //--------------------------------------------------
   always_ff @(posedge sys_clk18 or negedge n_sys_reset18)
   begin
      if (!n_sys_reset18)
         n_r_read <= 1'b0;
      else if (valid_access)
         n_r_read <= n_read;  // New access wins over done
      else if (access_end)
         n_r_read <= 1'b0;
   end

   //--------------------------------------------------
   // Chip select store
   //--------------------------------------------------
   // Same load priority as the direction
   always_ff @(posedge sys_clk18 or negedge n_sys_reset18)
   begin
      if (!n_sys_reset18)
         r_cs <= 1'b0;
      else if (valid_access)
         r_cs <= cs;
      else if (access_end)
         r_cs <= 1'b0;  // Deselect after the last access
   end

endmodule

// ==== smc_timing_pkg.sv ====
// Wait-state and edge-phase types, default byte lane count
package smc_timing_pkg;

   //--------------------------------------------------
   // Wait-state count or store
   //--------------------------------------------------
   // Compared as a whole or split into its two fields
   typedef struct packed
   {
      logic [5:0] coarse;  // Whole-cycle part
      logic [1:0] fine;    // Sub-phase part
   } ws_count_t;

   // Leading/trailing edge setting or counter
   typedef logic [1:0] edge_phase_t;

   // Default data bus width in byte lanes
   localparam int DEF_NUM_BYTES = 4;

endpackage

// ==== smc_state_pkg.sv ====
// Access state type shared by the strobe stages
package smc_state_pkg;

   //--------------------------------------------------
   // One-hot access state of the external FSM
   //--------------------------------------------------
   typedef enum logic [4:0]
   {
      IDLE  = 5'b00001,  // No access in progress
      LE    = 5'b00010,  // Leading edge wait
      RW    = 5'b00100,  // Strobe active
      STORE = 5'b01000,  // Data capture
      FLOAT = 5'b10000   // Bus turnaround
   } smc_state_e;

endpackage
